/* id_stage.f */
verilog/id_pkg.sv
verilog/id_decoder.sv
verilog/id_regfile.sv
verilog/id_stage_ctrl.sv
verilog/id_branch_unit.sv
verilog/id_stage.sv
verif/id_stage_tb.sv

/* Makefile */
VERILATOR ?= verilator
TB_TOP    ?= id_stage_tb
RTL_TOP   ?= id_stage
FLIST     ?= id_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) -f $(FLIST)

$(BUILD_DIR)/V$(TB_TOP): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) --binary --timing --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/id_stage_tb.sv */
// testbench with clock, reset, xorshift stimulus, reference decode, compare tasks, timeout
`default_nettype none

module id_stage_tb;

  localparam int N_ZERO    = 16;
  localparam int N_RAND    = 400;
  localparam int STALL_MAX = 12;  // worst wait per instruction from hazards and back-pressure
  localparam int LIMIT     = (N_ZERO + N_RAND) * STALL_MAX + 600;

  logic                           i_clk;
  logic                           i_arst_n;
  logic                           i_fs_valid;
  id_pkg::fs_to_ds_t              i_fs_bus;
  logic                           o_ds_allowin;
  logic                           o_ds_to_es_valid;
  id_pkg::ds_to_es_t              o_ds_to_es_bus;
  logic                           i_es_allowin;
  id_pkg::ws_to_rf_t              i_ws_to_rf;
  logic [id_pkg::REG_ADDR_WD-1:0] i_es_rd, i_ms_rd, i_ws_rd;
  id_pkg::br_t                    o_br;

  logic [63:0]       shadow [0:31];
  logic [31:0]       rng;
  id_pkg::fs_to_ds_t held_q [$];  // accepted and not yet left
  int                errors, checks, cycles, sent, left;
  logic              checking;

  id_stage dut_i (.*);

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [31:0] gen_inst();
    logic [31:0] w;
    logic [31:0] sel;
    logic        alt_ok;
    w   = next_rand();
    sel = next_rand() % 32'd13;
    case (sel)
      0: w[6:0] = 7'b0110111;
      1: w[6:0] = 7'b0010111;
      2: w[6:0] = 7'b1101111;
      3: begin
        w[6:0]   = 7'b1100111;
        w[14:12] = 3'b000;
      end
      4: begin
        w[6:0] = 7'b1100011;
        if (w[14:13] == 2'b01) w[14] = 1'b1;
      end
      5: begin
        w[6:0] = 7'b0000011;
        if (w[14:12] == 3'b111) w[14:12] = 3'b011;
      end
      6: begin
        w[6:0] = 7'b0100011;
        w[14]  = 1'b0;
      end
      7: begin
        w[6:0] = 7'b0010011;
        if (w[13:12] == 2'b01) w[31:26] = {1'b0, w[30] & w[14], 4'b0};  // shifts
      end
      8: begin
        w[6:0] = 7'b0011011;
        if (w[13:12] == 2'b01) w[31:25] = {1'b0, w[30] & w[14], 5'b0};
        else w[14:12] = 3'b000;
      end
      9, 10: begin
        w[6:0] = (sel == 32'd9) ? 7'b0110011 : 7'b0111011;
        if (sel == 32'd10 && w[13:12] != 2'b01) w[14:12] = 3'b000;
        alt_ok = (w[14:12] == 3'b000) || (w[14:12] == 3'b101);
        w[31:25] = {1'b0, w[30] & alt_ok, 5'b0};
      end
      11: w = 32'h0010_0073;
      default: if (w[31]) w[6:0] = 7'b0001011;  // custom-0 or a raw word
    endcase
    return w;
  endfunction

  function automatic logic [63:0] gen_val();
    logic [31:0] a, b;
    a = next_rand();
    b = next_rand();
    if (a[1:0] == 2'b00) return {{60{b[3]}}, b[3:0]};  // small values so compares tie
    return {a, b};
  endfunction

  function automatic id_pkg::alu_op_e alu_of(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0: return alt ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
      3'd1: return id_pkg::ALU_SLL;
      3'd2: return id_pkg::ALU_SLT;
      3'd3: return id_pkg::ALU_SLTU;
      3'd4: return id_pkg::ALU_XOR;
      3'd5: return alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
      3'd6: return id_pkg::ALU_OR;
      default: return id_pkg::ALU_AND;
    endcase
  endfunction

  // expected execute payload from the rv64i encoding rules
  function automatic id_pkg::ds_to_es_t ref_decode(input logic [31:0] in, input logic [63:0] pc);
    id_pkg::ds_to_es_t d;
    logic [2:0]        f3;
    logic [6:0]        f7;
    logic              ok;
    f3 = in[14:12];
    f7 = in[31:25];
    d  = '0;
    ok = 1'b1;
    d.ctrl.alu_src2 = id_pkg::SRC2_IMM;
    case (in[6:0])
      id_pkg::OP_LUI: begin
        d.imm = {{32{in[31]}}, in[31:12], 12'h000};
        d.ctrl.alu_op = id_pkg::ALU_LUI;
        d.ctrl.gpr_wen = 1'b1;
      end
      id_pkg::OP_AUIPC: begin
        d.imm = {{32{in[31]}}, in[31:12], 12'h000};
        d.ctrl.alu_src1 = id_pkg::SRC1_PC;
        d.ctrl.gpr_wen = 1'b1;
      end
      id_pkg::OP_JAL, id_pkg::OP_JALR: begin
        if (in[3]) d.imm = {{44{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
        else d.imm = {{52{in[31]}}, in[31:20]};
        ok = in[3] || (f3 == 3'd0);
        d.ctrl.alu_src1 = id_pkg::SRC1_PC;
        d.ctrl.alu_src2 = id_pkg::SRC2_FOUR;
        d.ctrl.gpr_wen = 1'b1;
      end
      id_pkg::OP_BRANCH: begin
        d.imm = {{52{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
        ok = (f3 != 3'd2) && (f3 != 3'd3);
      end
      id_pkg::OP_LOAD: begin
        d.imm = {{52{in[31]}}, in[31:20]};
        ok = (f3 != 3'd7);
        d.ctrl.gpr_wen = 1'b1;
        d.ctrl.mem_ren = 1'b1;
        d.ctrl.mem_op = f3;
      end
      id_pkg::OP_STORE: begin
        d.imm = {{52{in[31]}}, in[31:25], in[11:7]};
        ok = (f3 < 3'd4);
        d.ctrl.mem_wen = 1'b1;
        d.ctrl.mem_op = f3;
      end
      id_pkg::OP_IMM, id_pkg::OP_IMM32: begin
        d.imm = {{52{in[31]}}, in[31:20]};
        d.ctrl.word_cut = in[3];
        if (in[3]) ok = (f3 == 3'd0) || (f3 == 3'd1 && f7 == 7'h00) ||
                        (f3 == 3'd5 && (f7 == 7'h00 || f7 == 7'h20));
        else if (f3 == 3'd1) ok = (in[31:26] == 6'h00);
        else if (f3 == 3'd5) ok = (in[31:26] == 6'h00) || (in[31:26] == 6'h10);
        d.ctrl.alu_op = alu_of(f3, f3 == 3'd5 && in[30]);
        d.ctrl.gpr_wen = 1'b1;
      end
      id_pkg::OP_OP, id_pkg::OP_OP32: begin
        d.ctrl.word_cut = in[3];
        if (f7 == 7'h20) ok = (f3 == 3'd0) || (f3 == 3'd5);
        else ok = (f7 == 7'h00) && (!in[3] || f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5);
        d.ctrl.alu_src2 = id_pkg::SRC2_RS2;
        d.ctrl.alu_op = alu_of(f3, f7[5]);
        d.ctrl.gpr_wen = 1'b1;
      end
      id_pkg::OP_SYSTEM: begin
        ok = (in == 32'h0010_0073);
        d.ctrl.ebreak = ok;
      end
      default: ok = 1'b0;
    endcase
    if (!ok) begin
      d.ctrl.gpr_wen = 1'b0;
      d.ctrl.mem_ren = 1'b0;
      d.ctrl.mem_wen = 1'b0;
    end
    d.ctrl.invalid = !ok;
    d.rd      = d.ctrl.gpr_wen ? in[11:7] : 5'd0;
    d.rs1data = shadow[in[19:15]];
    d.rs2data = shadow[in[24:20]];
    d.pc      = pc;
    return d;
  endfunction

  function automatic logic [1:0] ref_uses(input logic [31:0] in);
    id_pkg::ds_to_es_t d;
    d = ref_decode(in, 64'd0);
    if (d.ctrl.invalid) return 2'b00;
    case (in[6:0])
      id_pkg::OP_JALR, id_pkg::OP_LOAD, id_pkg::OP_IMM, id_pkg::OP_IMM32: return 2'b01;
      id_pkg::OP_BRANCH, id_pkg::OP_STORE, id_pkg::OP_OP, id_pkg::OP_OP32: return 2'b11;
      default: return 2'b00;
    endcase
  endfunction

  function automatic logic is_xfer(input logic [31:0] in);
    id_pkg::ds_to_es_t d;
    logic              jump;
    jump = (in[6:0] == 7'b1100011) || (in[6:0] == 7'b1101111) || (in[6:0] == 7'b1100111);
    d    = ref_decode(in, 64'd0);
    return jump && !d.ctrl.invalid;
  endfunction

  function automatic id_pkg::br_t ref_branch(input logic [31:0] in, input id_pkg::ds_to_es_t d);
    id_pkg::br_t b;
    logic [63:0] a, c;
    a = d.rs1data;
    c = d.rs2data;
    b = '0;
    if (is_xfer(in)) begin
      case ({in[6:0] == 7'b1100011, in[14:12]})
        4'b1000: b.taken = (a == c);
        4'b1001: b.taken = (a != c);
        4'b1100: b.taken = ($signed(a) < $signed(c));
        4'b1101: b.taken = ($signed(a) >= $signed(c));
        4'b1110: b.taken = (a < c);
        4'b1111: b.taken = (a >= c);
        default: b.taken = 1'b1;  // jal, jalr
      endcase
      b.target = (in[6:0] == 7'b1100111) ? ((a + d.imm) & ~64'd1) : (d.pc + d.imm);
    end
    return b;
  endfunction

  task automatic check_bit(input string name, input logic exp, input logic got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s expected %h got %h", name, exp, got);
    end
  endtask

  task automatic check_payload(input id_pkg::ds_to_es_t exp, input id_pkg::ds_to_es_t got);
    logic ok;
    checks++;
    if (!exp.ctrl.invalid) ok = (got === exp);
    else ok = ({got.rs1data, got.rs2data, got.pc, got.rd, got.ctrl.gpr_wen, got.ctrl.mem_ren,
                got.ctrl.mem_wen, got.ctrl.invalid} ===
               {exp.rs1data, exp.rs2data, exp.pc, exp.rd, exp.ctrl.gpr_wen, exp.ctrl.mem_ren,
                exp.ctrl.mem_wen, exp.ctrl.invalid});
    if (!ok) begin
      errors++;
      $display("Error: o_ds_to_es_bus expected %h got %h", exp, got);
    end
  endtask

  task automatic check_branch(input id_pkg::br_t exp, input id_pkg::br_t got);
    checks++;
    if (got.taken !== exp.taken || (exp.taken && got.target !== exp.target)) begin
      errors++;
      $display("Error: o_br expected %h got %h", exp, got);
    end
  endtask

  // compare at every edge against the held instruction
  always @(posedge i_clk) begin
    id_pkg::ds_to_es_t exp;
    logic [1:0]        use_m;
    logic [31:0]       in;
    logic              haz, go;
    if (checking) begin
      go = 1'b0;
      if (held_q.size() > 0) begin
        in    = held_q[0].inst;
        exp   = ref_decode(in, held_q[0].pc);
        use_m = ref_uses(in);
        haz = ((i_es_rd != 5'd0) && ((use_m[0] && i_es_rd == in[19:15]) ||
                                     (use_m[1] && i_es_rd == in[24:20]))) ||
              ((i_ms_rd != 5'd0) && ((use_m[0] && i_ms_rd == in[19:15]) ||
                                     (use_m[1] && i_ms_rd == in[24:20]))) ||
              ((i_ws_rd != 5'd0) && ((use_m[0] && i_ws_rd == in[19:15]) ||
                                     (use_m[1] && i_ws_rd == in[24:20])));
        check_bit("o_ds_to_es_valid", !haz, o_ds_to_es_valid);
        check_bit("o_br.stall", haz && is_xfer(in), o_br.stall);
        go = !haz && i_es_allowin;
        check_bit("o_ds_allowin", go, o_ds_allowin);
        if (go) begin
          check_payload(exp, o_ds_to_es_bus);
          check_branch(ref_branch(in, exp), o_br);
          void'(held_q.pop_front());
          left++;
        end else begin
          check_bit("o_br.taken", 1'b0, o_br.taken);
        end
      end else begin
        check_bit("o_ds_to_es_valid", 1'b0, o_ds_to_es_valid);
        check_bit("o_br.taken", 1'b0, o_br.taken);
        check_bit("o_ds_allowin", 1'b1, o_ds_allowin);
      end
      if (i_fs_valid && o_ds_allowin) held_q.push_back(i_fs_bus);
    end
  end

  always @(posedge i_clk) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("run timed out after %0d cycles with %0d of %0d instructions out",
               cycles, left, sent);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic report(input string name, input int err0, input int chk0);
    $display("test %s: %0d checks, %0d errors", name, checks - chk0, errors - err0);
  endtask

  // feed n instructions with optional hazards and back-pressure
  task automatic run_stream(input int n, input logic stress);
    logic [31:0] pend, held, r;
    logic [63:0] pc;
    int          done;
    done = 0;
    pend = gen_inst();
    pc   = {32'h0, next_rand() & 32'hffff_fffc};
    held = 32'h0;
    while (done < n) begin
      @(posedge i_clk);
      if (i_fs_valid && o_ds_allowin) begin
        held = pend;
        done++;
        sent++;
        pend = gen_inst();
        pc   = pc + 64'd4;
      end
      r = next_rand();
      i_fs_valid   <= (done < n) && (r[1:0] != 2'b00);
      i_fs_bus     <= {pend, pc};
      i_es_allowin <= !stress || (r[3:2] != 2'b00);
      i_es_rd      <= (stress && r[6:4] == 3'd0) ? held[19:15] : 5'd0;
      i_ms_rd      <= (stress && r[9:7] == 3'd0) ? held[24:20] : 5'd0;
      i_ws_rd      <= (stress && r[11:10] == 2'd0) ? r[16:12] : 5'd0;
    end
    @(posedge i_clk);
    i_fs_valid   <= 1'b0;
    i_es_allowin <= 1'b1;
    i_es_rd      <= 5'd0;
    i_ms_rd      <= 5'd0;
    i_ws_rd      <= 5'd0;
    while (left != sent) @(posedge i_clk);
  endtask

  initial begin
    int e0, c0;
    rng = 32'd97;
    errors = 0;
    checks = 0;
    cycles = 0;
    sent = 0;
    left = 0;
    checking = 1'b0;
    i_arst_n = 1'b0;
    i_fs_valid = 1'b0;
    i_fs_bus = '0;
    i_es_allowin = 1'b1;
    i_ws_to_rf = '0;
    i_es_rd = 5'd0;
    i_ms_rd = 5'd0;
    i_ws_rd = 5'd0;
    for (int i = 0; i < 32; i++) shadow[i] = 64'd0;
    repeat (3) @(posedge i_clk);
    i_arst_n <= 1'b1;
    @(posedge i_clk);
    e0 = errors;
    c0 = checks;
    check_bit("o_ds_to_es_valid", 1'b0, o_ds_to_es_valid);
    check_bit("o_br.taken", 1'b0, o_br.taken);
    check_bit("o_br.stall", 1'b0, o_br.stall);
    check_bit("o_ds_allowin", 1'b1, o_ds_allowin);
    checking = 1'b1;
    report("reset_state", e0, c0);

    // registers still zero from reset
    e0 = errors;
    c0 = checks;
    run_stream(N_ZERO, 1'b0);
    report("zero_regs", e0, c0);

    // fill the file including an ignored x0 write
    for (int i = 0; i < 32; i++) begin
      @(posedge i_clk);
      i_ws_to_rf <= {1'b1, i[4:0], gen_val()};
      @(posedge i_clk);
      i_ws_to_rf.wen <= 1'b0;
      if (i != 0) shadow[i] = i_ws_to_rf.wdata;
    end
    @(posedge i_clk);

    e0 = errors;
    c0 = checks;
    run_stream(N_RAND, 1'b1);
    report("random_stream", e0, c0);

    $display("total: %0d checks, %0d errors, %0d instructions", checks, errors, left);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/id_stage.sv */
// id_stage: decode stage top, control, decoder, regfile, branch unit, execute payload
`default_nettype none

module id_stage (
  input  logic                           i_clk,
  input  logic                           i_arst_n,
  // fetch
  input  logic                           i_fs_valid,
  input  id_pkg::fs_to_ds_t              i_fs_bus,
  output logic                           o_ds_allowin,
  // execute
  output logic                           o_ds_to_es_valid,
  output id_pkg::ds_to_es_t              o_ds_to_es_bus,
  input  logic                           i_es_allowin,
  // writeback to regfile
  input  id_pkg::ws_to_rf_t              i_ws_to_rf,
  // downstream destinations for hazard check
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_es_rd,
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_ms_rd,
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_ws_rd,
  // to fetch
  output id_pkg::br_t                    o_br
);

  logic                           ds_valid, ds_stall, ds_ready;
  logic [id_pkg::INST_WD-1:0]     ds_inst;
  logic [id_pkg::XLEN-1:0]        ds_pc;
  logic [id_pkg::REG_ADDR_WD-1:0] rs1, rs2, rd;
  logic                           uses_rs1, uses_rs2;
  logic [id_pkg::XLEN-1:0]        rs1data, rs2data, imm;
  id_pkg::ctrl_t                  ctrl;
  logic                           bren, jal, jalr;
  logic [2:0]                     brfunc;
  logic                           br_sel;
  logic [id_pkg::XLEN-1:0]        br_target;

  id_stage_ctrl u_ctrl (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_fs_valid   (i_fs_valid),
    .i_fs_bus     (i_fs_bus),
    .o_ds_allowin (o_ds_allowin),
    .i_es_allowin (i_es_allowin),
    .i_es_rd      (i_es_rd),
    .i_ms_rd      (i_ms_rd),
    .i_ws_rd      (i_ws_rd),
    .i_rs1        (rs1),
    .i_rs2        (rs2),
    .i_uses_rs1   (uses_rs1),
    .i_uses_rs2   (uses_rs2),
    .o_valid      (ds_valid),
    .o_inst       (ds_inst),
    .o_pc         (ds_pc),
    .o_stall      (ds_stall),
    .o_ready      (ds_ready)
  );

  id_decoder u_dec (
    .i_inst     (ds_inst),
    .o_rs1      (rs1),
    .o_rs2      (rs2),
    .o_rd       (rd),
    .o_uses_rs1 (uses_rs1),
    .o_uses_rs2 (uses_rs2),
    .o_imm      (imm),
    .o_ctrl     (ctrl),
    .o_bren     (bren),
    .o_brfunc   (brfunc),
    .o_jal      (jal),
    .o_jalr     (jalr)
  );

  id_regfile u_gprs (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_raddr1 (rs1),
    .o_rdata1 (rs1data),
    .i_raddr2 (rs2),
    .o_rdata2 (rs2data),
    .i_wr     (i_ws_to_rf)
  );

  id_branch_unit u_bru (
    .i_rs1data   (rs1data),
    .i_rs2data   (rs2data),
    .i_pc        (ds_pc),
    .i_imm       (imm),
    .i_bren      (bren),
    .i_brfunc    (brfunc),
    .i_jal       (jal),
    .i_jalr      (jalr),
    .o_br_sel    (br_sel),
    .o_br_target (br_target)
  );

  assign o_ds_to_es_valid = ds_ready;

  always_comb begin
    o_ds_to_es_bus.rs1data = rs1data;
    o_ds_to_es_bus.rs2data = rs2data;
    o_ds_to_es_bus.imm     = imm;
    o_ds_to_es_bus.pc      = ds_pc;
    o_ds_to_es_bus.rd      = rd;
    o_ds_to_es_bus.ctrl    = ctrl;
  end

  // fetch holds off while a control transfer waits on operands
  assign o_br.stall  = ds_valid && ds_stall && (bren || jal || jalr);
  assign o_br.taken  = o_ds_to_es_valid && i_es_allowin && br_sel;  // only at transfer
  assign o_br.target = br_target;

endmodule

`default_nettype wire

/* verilog/id_branch_unit.sv */
// id_branch_unit: branch condition and target for branches and jumps
`default_nettype none

module id_branch_unit (
  input  logic [id_pkg::XLEN-1:0] i_rs1data,
  input  logic [id_pkg::XLEN-1:0] i_rs2data,
  input  logic [id_pkg::XLEN-1:0] i_pc,
  input  logic [id_pkg::XLEN-1:0] i_imm,
  input  logic                    i_bren,
  input  logic [2:0]              i_brfunc,
  input  logic                    i_jal,
  input  logic                    i_jalr,
  output logic                    o_br_sel,
  output logic [id_pkg::XLEN-1:0] o_br_target
);

  logic                    eq;
  logic                    lt;
  logic                    ltu;
  logic                    cond;
  logic [id_pkg::XLEN-1:0] base;
  logic [id_pkg::XLEN-1:0] sum;

  assign eq  = (i_rs1data == i_rs2data);
  assign lt  = ($signed(i_rs1data) < $signed(i_rs2data));
  assign ltu = (i_rs1data < i_rs2data);

  always_comb begin
    case (i_brfunc)
      3'b000:  cond = eq;    // beq
      3'b001:  cond = !eq;   // bne
      3'b100:  cond = lt;
      3'b101:  cond = !lt;   // bge
      3'b110:  cond = ltu;
      3'b111:  cond = !ltu;  // bgeu
      default: cond = 1'b0;
    endcase
  end

  // jalr is relative to rs1, the rest to pc
  assign base = i_jalr ? i_rs1data : i_pc;
  assign sum  = base + i_imm;

  assign o_br_target = i_jalr ? {sum[id_pkg::XLEN-1:1], 1'b0} : sum;
  assign o_br_sel    = i_jal || i_jalr || (i_bren && cond);

endmodule

`default_nettype wire

/* verilog/id_stage_ctrl.sv */
// stage valid bit, fetch payload latch, hazard check, allowin/ready
`default_nettype none

module id_stage_ctrl (
  input  logic                           i_clk,
  input  logic                           i_arst_n,
  // from fetch
  input  logic                           i_fs_valid,
  input  id_pkg::fs_to_ds_t              i_fs_bus,
  output logic                           o_ds_allowin,
  // from execute
  input  logic                           i_es_allowin,
  // destinations still in flight
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_es_rd,
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_ms_rd,
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_ws_rd,
  // sources of the held instruction
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_rs1,
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_rs2,
  input  logic                           i_uses_rs1,
  input  logic                           i_uses_rs2,
  // held instruction and status
  output logic                           o_valid,
  output logic [id_pkg::INST_WD-1:0]     o_inst,
  output logic [id_pkg::XLEN-1:0]        o_pc,
  output logic                           o_stall,
  output logic                           o_ready
);

  logic              ds_valid;
  id_pkg::fs_to_ds_t fs_bus_r;
  logic              hazard;

  function automatic logic rd_hit(input logic [id_pkg::REG_ADDR_WD-1:0] rd);
    logic hit1, hit2;
    hit1 = i_uses_rs1 && (rd == i_rs1);
    hit2 = i_uses_rs2 && (rd == i_rs2);
    return (rd != '0) && (hit1 || hit2);
  endfunction

  always_comb begin
    hazard = rd_hit(i_es_rd) || rd_hit(i_ms_rd) || rd_hit(i_ws_rd);
  end

  assign o_ready      = ds_valid && !hazard;
  assign o_ds_allowin = !ds_valid || (o_ready && i_es_allowin);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_valid && o_ds_allowin) begin
      fs_bus_r <= i_fs_bus;
    end
  end

  assign o_valid = ds_valid;
  assign o_inst  = fs_bus_r.inst;
  assign o_pc    = fs_bus_r.pc;
  assign o_stall = hazard;  // qualified with valid in the top

endmodule

`default_nettype wire

/* verilog/id_regfile.sv */
// id_regfile: 32x64 gpr file, two async read ports, one writeback port
`default_nettype none

module id_regfile (
  input  logic                           i_clk,
  input  logic                           i_arst_n,
  // read port 1
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_raddr1,
  output logic [id_pkg::XLEN-1:0]        o_rdata1,
  // read port 2
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_raddr2,
  output logic [id_pkg::XLEN-1:0]        o_rdata2,
  // from writeback
  input  id_pkg::ws_to_rf_t              i_wr
);

  // x0 has no storage
  logic [id_pkg::XLEN-1:0] regs [1:31];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr.wen && i_wr.waddr != '0) begin
      regs[i_wr.waddr] <= i_wr.wdata;
    end
  end

  // no bypass, old value seen on a write cycle
  always_comb begin
    o_rdata1 = '0;
    o_rdata2 = '0;
    if (i_raddr1 != '0) begin
      o_rdata1 = regs[i_raddr1];
    end
    if (i_raddr2 != '0) begin
      o_rdata2 = regs[i_raddr2];
    end
  end

endmodule

`default_nettype wire

/* verilog/id_decoder.sv */
// id_decoder: rv64i decode into register indices, immediate and control
`default_nettype none

module id_decoder (
  input  logic [id_pkg::INST_WD-1:0]     i_inst,
  output logic [id_pkg::REG_ADDR_WD-1:0] o_rs1,
  output logic [id_pkg::REG_ADDR_WD-1:0] o_rs2,
  output logic [id_pkg::REG_ADDR_WD-1:0] o_rd,
  output logic                           o_uses_rs1,
  output logic                           o_uses_rs2,
  output logic [id_pkg::XLEN-1:0]        o_imm,
  output id_pkg::ctrl_t                  o_ctrl,
  output logic                           o_bren,
  output logic [2:0]                     o_brfunc,
  output logic                           o_jal,
  output logic                           o_jalr
);

  logic [6:0]              opcode;
  logic [2:0]              funct3;
  logic [6:0]              funct7;
  logic [id_pkg::XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic                    legal;
  logic                    uses_rs1, uses_rs2;
  logic                    bren, jal, jalr;
  id_pkg::ctrl_t           ctrl;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  // funct3 to alu op, alt picks sub/sra
  function automatic id_pkg::alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt);
    id_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = alt ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
      3'b001:  op = id_pkg::ALU_SLL;
      3'b010:  op = id_pkg::ALU_SLT;
      3'b011:  op = id_pkg::ALU_SLTU;
      3'b100:  op = id_pkg::ALU_XOR;
      3'b101:  op = alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
      3'b110:  op = id_pkg::ALU_OR;
      default: op = id_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    ctrl.alu_src1 = id_pkg::SRC1_RS1;
    ctrl.alu_src2 = id_pkg::SRC2_IMM;
    ctrl.alu_op   = id_pkg::ALU_ADD;
    ctrl.word_cut = 1'b0;
    ctrl.gpr_wen  = 1'b0;
    ctrl.mem_ren  = 1'b0;
    ctrl.mem_wen  = 1'b0;
    ctrl.mem_op   = 3'b000;
    ctrl.ebreak   = 1'b0;
    ctrl.invalid  = 1'b0;
    o_imm         = '0;
    legal         = 1'b0;
    uses_rs1      = 1'b0;
    uses_rs2      = 1'b0;
    bren          = 1'b0;
    jal           = 1'b0;
    jalr          = 1'b0;

    case (id_pkg::opcode_e'(opcode))
      id_pkg::OP_LUI: begin
        legal        = 1'b1;
        o_imm        = imm_u;
        ctrl.alu_op  = id_pkg::ALU_LUI;
        ctrl.gpr_wen = 1'b1;
      end
      id_pkg::OP_AUIPC: begin
        legal         = 1'b1;
        o_imm         = imm_u;
        ctrl.alu_src1 = id_pkg::SRC1_PC;
        ctrl.gpr_wen  = 1'b1;
      end
      id_pkg::OP_JAL, id_pkg::OP_JALR: begin
        legal         = (opcode == id_pkg::OP_JAL) || (funct3 == 3'b000);
        jal           = (opcode == id_pkg::OP_JAL);
        jalr          = (opcode == id_pkg::OP_JALR);
        uses_rs1      = jalr;
        o_imm         = jal ? imm_j : imm_i;
        ctrl.alu_src1 = id_pkg::SRC1_PC;  // rd = pc + 4
        ctrl.alu_src2 = id_pkg::SRC2_FOUR;
        ctrl.gpr_wen  = 1'b1;
      end
      id_pkg::OP_BRANCH: begin
        legal    = (funct3[2:1] != 2'b01);
        bren     = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        o_imm    = imm_b;
      end
      id_pkg::OP_LOAD: begin
        legal        = (funct3 != 3'b111);
        uses_rs1     = 1'b1;
        o_imm        = imm_i;
        ctrl.gpr_wen = 1'b1;
        ctrl.mem_ren = 1'b1;
        ctrl.mem_op  = funct3;
      end
      id_pkg::OP_STORE: begin
        legal        = !funct3[2];
        uses_rs1     = 1'b1;
        uses_rs2     = 1'b1;
        o_imm        = imm_s;
        ctrl.mem_wen = 1'b1;
        ctrl.mem_op  = funct3;
      end
      id_pkg::OP_IMM, id_pkg::OP_IMM32: begin
        ctrl.word_cut = (opcode == id_pkg::OP_IMM32);
        if (ctrl.word_cut) begin
          legal = (funct3 == 3'b000) || (funct3 == 3'b001 && funct7 == 7'b0) ||
                  (funct3 == 3'b101 && (funct7 == 7'b0 || funct7 == 7'b0100000));
        end else begin
          legal = (funct3 != 3'b001 && funct3 != 3'b101) ||
                  (funct3 == 3'b001 && i_inst[31:26] == 6'b0) ||
                  (funct3 == 3'b101 && (i_inst[31:26] == 6'b0 || i_inst[31:26] == 6'b010000));
        end
        uses_rs1     = 1'b1;
        o_imm        = imm_i;
        ctrl.alu_op  = f3_to_alu(funct3, funct3 == 3'b101 && i_inst[30]);
        ctrl.gpr_wen = 1'b1;
      end
      id_pkg::OP_OP, id_pkg::OP_OP32: begin
        ctrl.word_cut = (opcode == id_pkg::OP_OP32);
        legal = (funct7 == 7'b0 &&
                 (!ctrl.word_cut || funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101)) ||
                (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
        uses_rs1      = 1'b1;
        uses_rs2      = 1'b1;
        ctrl.alu_src2 = id_pkg::SRC2_RS2;
        ctrl.alu_op   = f3_to_alu(funct3, funct7[5]);
        ctrl.gpr_wen  = 1'b1;
      end
      id_pkg::OP_SYSTEM: begin
        legal       = (i_inst == 32'h0010_0073);  // ebreak only
        ctrl.ebreak = legal;
      end
      default: legal = 1'b0;
    endcase

    // illegal encodings must not touch state
    if (!legal) begin
      ctrl.gpr_wen = 1'b0;
      ctrl.mem_ren = 1'b0;
      ctrl.mem_wen = 1'b0;
      uses_rs1     = 1'b0;
      uses_rs2     = 1'b0;
      bren         = 1'b0;
      jal          = 1'b0;
      jalr         = 1'b0;
    end
    ctrl.invalid = !legal;
  end

  assign o_rs1      = i_inst[19:15];
  assign o_rs2      = i_inst[24:20];
  assign o_rd       = ctrl.gpr_wen ? i_inst[11:7] : '0;  // zero when nothing written
  assign o_uses_rs1 = uses_rs1;
  assign o_uses_rs2 = uses_rs2;
  assign o_ctrl     = ctrl;
  assign o_bren     = bren;
  assign o_brfunc   = funct3;
  assign o_jal      = jal;
  assign o_jalr     = jalr;

endmodule

`default_nettype wire

/* verilog/id_pkg.sv */
// widths, opcode and alu enums, fetch/writeback/execute/branch bus structs
`default_nettype none

package id_pkg;

  localparam int XLEN        = 64;
  localparam int INST_WD     = 32;
  localparam int REG_ADDR_WD = 5;

  // rv64i major opcodes handled here
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_OP     = 7'b0110011,
    OP_IMM32  = 7'b0011011,
    OP_OP32   = 7'b0111011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9,
    ALU_LUI  = 4'd10  // pass src2 through
  } alu_op_e;

  typedef enum logic {
    SRC1_RS1 = 1'b0,
    SRC1_PC  = 1'b1
  } alu_src1_e;

  typedef enum logic [1:0] {
    SRC2_RS2  = 2'd0,
    SRC2_IMM  = 2'd1,
    SRC2_FOUR = 2'd2  // link address for jumps
  } alu_src2_e;

  typedef struct packed {
    logic [INST_WD-1:0] inst;
    logic [XLEN-1:0]    pc;
  } fs_to_ds_t;

  typedef struct packed {
    logic                   wen;
    logic [REG_ADDR_WD-1:0] waddr;
    logic [XLEN-1:0]        wdata;
  } ws_to_rf_t;

  typedef struct packed {
    alu_src1_e  alu_src1;
    alu_src2_e  alu_src2;
    alu_op_e    alu_op;
    logic       word_cut;  // *w ops, result sign-extended from 32 bits
    logic       gpr_wen;
    logic       mem_ren;
    logic       mem_wen;
    logic [2:0] mem_op;    // load/store funct3
    logic       ebreak;
    logic       invalid;
  } ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0]        rs1data;
    logic [XLEN-1:0]        rs2data;
    logic [XLEN-1:0]        imm;
    logic [XLEN-1:0]        pc;
    logic [REG_ADDR_WD-1:0] rd;
    ctrl_t                  ctrl;
  } ds_to_es_t;

  typedef struct packed {
    logic            stall;
    logic            taken;
    logic [XLEN-1:0] target;
  } br_t;

endpackage

`default_nettype wire
